// ==== alu_pkg.sv ====
package alu_pkg;

    // reorder-buffer index width
    localparam int ROB_IDX_W = 3;

    // major opcodes handled by the cluster
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // register-immediate

    // funct3 encodings shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values, alt selects sub and sra
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        add    = 4'd0,
        sub    = 4'd1,
        and_op = 4'd2,
        or_op  = 4'd3,
        xor_op = 4'd4,
        slt    = 4'd5,
        sltu   = 4'd6,
        sll    = 4'd7,
        srl    = 4'd8,
        sra    = 4'd9
    } alu_func_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_t;

    // one instruction word, read as R-type or as I-type
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
    } rv_instr_t;

endpackage

// ==== alu_decode.sv ====
module alu_decode (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          instr_valid,
    input  alu_pkg::rv_instr_t            instr,
    input  logic [31:0]                   rs1_val,
    input  logic [31:0]                   rs2_val,
    input  logic [alu_pkg::ROB_IDX_W-1:0] rob_idx,
    input  logic                          q_ready,
    output logic                          instr_ready,
    output logic                          dec_valid,
    output alu_pkg::alu_func_t            dec_func,
    output logic [31:0]                   dec_op_a,
    output logic [31:0]                   dec_op_b,
    output logic [alu_pkg::ROB_IDX_W-1:0] dec_rob_idx,
    output logic                          dec_illegal
);
    import alu_pkg::*;

    alu_func_t   func_d;
    logic [31:0] op_a_d;
    logic [31:0] op_b_d;
    logic        illegal_d;
    logic        take;

    // funct3 plus the alt bit (funct7[5]) to a function
    function automatic alu_func_t base_func(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? sub : add;
            F3_SLL:     return sll;
            F3_SLT:     return slt;
            F3_SLTU:    return sltu;
            F3_XOR:     return xor_op;
            F3_SR:      return alt ? sra : srl;
            F3_OR:      return or_op;
            default:    return and_op;  // F3_AND
        endcase
    endfunction

    // register can move when empty or when the queue takes it
    assign instr_ready = !dec_valid || q_ready;
    assign take        = instr_valid && instr_ready;

    always_comb begin
        func_d    = add;
        op_b_d    = rs2_val;
        illegal_d = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin
                // only sub and sra may carry the alt funct7
                if (instr.r.funct7 == F7_BASE) begin
                    func_d = base_func(instr.r.funct3, 1'b0);
                end else if (instr.r.funct7 == F7_ALT &&
                             (instr.r.funct3 == F3_ADD_SUB || instr.r.funct3 == F3_SR)) begin
                    func_d = base_func(instr.r.funct3, 1'b1);
                end else begin
                    illegal_d = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (instr.i.funct3 == F3_SLL || instr.i.funct3 == F3_SR) begin
                    // shift amount lives in imm12[4:0], funct7 in imm12[11:5]
                    op_b_d = {27'b0, instr.i.imm12[4:0]};
                    if (instr.i.imm12[11:5] == F7_BASE) begin
                        func_d = base_func(instr.i.funct3, 1'b0);
                    end else if (instr.i.imm12[11:5] == F7_ALT && instr.i.funct3 == F3_SR) begin
                        func_d = sra;
                    end else begin
                        illegal_d = 1'b1;
                    end
                end else begin
                    func_d = base_func(instr.i.funct3, 1'b0);  // no subi
                    op_b_d = {{20{instr.i.imm12[11]}}, instr.i.imm12};
                end
            end
            default: illegal_d = 1'b1;
        endcase

        // illegal ops become add 0 + 0
        if (illegal_d) begin
            func_d = add;
            op_b_d = '0;
        end
        op_a_d = illegal_d ? 32'b0 : rs1_val;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            dec_valid <= 1'b0;
        end else if (instr_ready) begin
            dec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            dec_func    <= func_d;
            dec_op_a    <= op_a_d;
            dec_op_b    <= op_b_d;
            dec_rob_idx <= rob_idx;
            dec_illegal <= illegal_d;
        end
    end

endmodule

// ==== alu_issue_queue.sv ====
module alu_issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          dec_valid,
    input  alu_pkg::alu_func_t            dec_func,
    input  logic [31:0]                   dec_op_a,
    input  logic [31:0]                   dec_op_b,
    input  logic [alu_pkg::ROB_IDX_W-1:0] dec_rob_idx,
    input  logic                          dec_illegal,
    input  logic                          alu_busy,
    output logic                          q_ready,
    output logic                          iss_valid,
    output alu_pkg::alu_func_t            iss_func,
    output logic [31:0]                   iss_op_a,
    output logic [31:0]                   iss_op_b,
    output logic [alu_pkg::ROB_IDX_W-1:0] iss_rob_idx,
    output logic                          iss_illegal
);
    import alu_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // entry storage
    alu_func_t            func_mem    [QUEUE_DEPTH];
    logic [31:0]          op_a_mem    [QUEUE_DEPTH];
    logic [31:0]          op_b_mem    [QUEUE_DEPTH];
    logic [ROB_IDX_W-1:0] rob_idx_mem [QUEUE_DEPTH];
    logic                 illegal_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wrap at QUEUE_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign pop  = (count != '0) && !alu_busy;
    assign push = dec_valid && q_ready;

    // full queue still accepts when the head leaves this cycle
    assign q_ready = (count != CNT_W'(QUEUE_DEPTH)) || pop;

    assign iss_valid   = pop;
    assign iss_func    = func_mem[rd_ptr];
    assign iss_op_a    = op_a_mem[rd_ptr];
    assign iss_op_b    = op_b_mem[rd_ptr];
    assign iss_rob_idx = rob_idx_mem[rd_ptr];
    assign iss_illegal = illegal_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) begin
            func_mem[wr_ptr]    <= dec_func;
            op_a_mem[wr_ptr]    <= dec_op_a;
            op_b_mem[wr_ptr]    <= dec_op_b;
            rob_idx_mem[wr_ptr] <= dec_rob_idx;
            illegal_mem[wr_ptr] <= dec_illegal;
        end
    end

endmodule

// ==== alu.sv ====
module alu #(
    parameter int ALU_LATENCY = 5
) (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          iss_valid,
    input  alu_pkg::alu_func_t            iss_func,
    input  logic [31:0]                   iss_op_a,
    input  logic [31:0]                   iss_op_b,
    input  logic [alu_pkg::ROB_IDX_W-1:0] iss_rob_idx,
    input  logic                          iss_illegal,
    output logic                          alu_busy,
    output logic                          result_valid,
    output logic [31:0]                   result_data,
    output logic [alu_pkg::ROB_IDX_W-1:0] result_rob_idx,
    output logic                          result_illegal
);
    import alu_pkg::*;

    logic [ALU_LATENCY-1:0] stall;       // one-hot, walks toward the msb
    logic [ALU_LATENCY-1:0] stall_next;
    logic [4:0]             shamt;
    logic [31:0]            alu_out;

    assign shamt = iss_op_b[4:0];  // rv32i shifts use 5 bits

    // busy while the token is in flight, low again in the pulse cycle
    assign alu_busy = |stall;

    always_comb begin
        alu_out = '0;
        case (iss_func)
            add:    alu_out = iss_op_a + iss_op_b;
            sub:    alu_out = iss_op_a - iss_op_b;
            and_op: alu_out = iss_op_a & iss_op_b;
            or_op:  alu_out = iss_op_a | iss_op_b;
            xor_op: alu_out = iss_op_a ^ iss_op_b;
            slt:    alu_out = {31'b0, $signed(iss_op_a) < $signed(iss_op_b)};
            sltu:   alu_out = {31'b0, iss_op_a < iss_op_b};
            sll:    alu_out = iss_op_a << shamt;
            srl:    alu_out = iss_op_a >> shamt;  // zero fill
            sra:    alu_out = $signed(iss_op_a) >>> shamt;  // sign fill
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        stall_next    = stall << 1;
        stall_next[0] = iss_valid;  // new token on issue
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stall        <= '0;
            result_valid <= 1'b0;
        end else begin
            stall        <= stall_next;
            result_valid <= stall[ALU_LATENCY-1];
        end
    end

    // computed once at issue, held until the pulse
    always_ff @(posedge clk_in) begin
        if (iss_valid) begin
            result_data    <= alu_out;
            result_rob_idx <= iss_rob_idx;
            result_illegal <= iss_illegal;
        end
    end

endmodule

// ==== alu_cluster.sv ====
module alu_cluster #(
    parameter int QUEUE_DEPTH = 4,
    parameter int ALU_LATENCY = 5
) (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          instr_valid,
    input  alu_pkg::rv_instr_t            instr,
    input  logic [31:0]                   rs1_val,
    input  logic [31:0]                   rs2_val,
    input  logic [alu_pkg::ROB_IDX_W-1:0] rob_idx,
    output logic                          instr_ready,
    output logic                          result_valid,
    output logic [31:0]                   result_data,
    output logic [alu_pkg::ROB_IDX_W-1:0] result_rob_idx,
    output logic                          result_illegal
);
    import alu_pkg::*;

    // decoder to queue
    logic                 dec_valid;
    alu_func_t            dec_func;
    logic [31:0]          dec_op_a;
    logic [31:0]          dec_op_b;
    logic [ROB_IDX_W-1:0] dec_rob_idx;
    logic                 dec_illegal;
    logic                 q_ready;

    // queue to alu
    logic                 iss_valid;
    alu_func_t            iss_func;
    logic [31:0]          iss_op_a;
    logic [31:0]          iss_op_b;
    logic [ROB_IDX_W-1:0] iss_rob_idx;
    logic                 iss_illegal;
    logic                 alu_busy;

    alu_decode u_decode (
        .clk_in, .rst_in, .instr_valid, .instr, .rs1_val, .rs2_val, .rob_idx, .q_ready,
        .instr_ready, .dec_valid, .dec_func, .dec_op_a, .dec_op_b, .dec_rob_idx, .dec_illegal
    );

    alu_issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk_in, .rst_in, .dec_valid, .dec_func, .dec_op_a, .dec_op_b, .dec_rob_idx,
        .dec_illegal, .alu_busy, .q_ready, .iss_valid, .iss_func, .iss_op_a, .iss_op_b,
        .iss_rob_idx, .iss_illegal
    );

    alu #(.ALU_LATENCY(ALU_LATENCY)) u_alu (
        .clk_in, .rst_in, .iss_valid, .iss_func, .iss_op_a, .iss_op_b, .iss_rob_idx,
        .iss_illegal, .alu_busy, .result_valid, .result_data, .result_rob_idx, .result_illegal
    );

endmodule

// ==== alu_cluster_tb.sv ====
module alu_cluster_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import alu_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int ALU_LATENCY = 3;
    localparam int WAIT_LIMIT  = 200;  // cycles per wait

    typedef struct {
        rv_instr_t            word;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [ROB_IDX_W-1:0] idx;
        int                   gap;       // nonzero: idle cycles, then wait for drain
        logic [31:0]          exp_data;
        logic                 exp_ill;
    } row_t;

    typedef struct {
        logic [31:0]          data;
        logic [ROB_IDX_W-1:0] idx;
        logic                 ill;
        logic                 timed;
        int                   xfer;      // cycle of the transfer edge
    } exp_t;

    logic                 clk_in;
    logic                 rst_in;
    logic                 instr_valid;
    rv_instr_t            instr;
    logic [31:0]          rs1_val;
    logic [31:0]          rs2_val;
    logic [ROB_IDX_W-1:0] rob_idx;
    logic                 instr_ready;
    logic                 result_valid;
    logic [31:0]          result_data;
    logic [ROB_IDX_W-1:0] result_rob_idx;
    logic                 result_illegal;

    row_t   rows[$];
    exp_t   exp_q[$];          // scoreboard, oldest first
    int     cycle = 0;
    int     check_count = 0;
    int     mismatch_count = 0;
    int     other_count = 0;
    logic   timed_out = 1'b0;
    logic   saw_stall = 1'b0;
    integer seed = 10162;

    alu_cluster #(.QUEUE_DEPTH(QUEUE_DEPTH), .ALU_LATENCY(ALU_LATENCY)) uut (
        .clk_in, .rst_in, .instr_valid, .instr, .rs1_val, .rs2_val, .rob_idx,
        .instr_ready, .result_valid, .result_data, .result_rob_idx, .result_illegal
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    always @(posedge clk_in) cycle <= cycle + 1;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        other_count++;
        timed_out = 1'b1;
        $display("timeout after %0d cycles while %s", WAIT_LIMIT, what);
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #1;  // inputs change just after the edge
    endtask

    function automatic rv_instr_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] opc);
        rv_instr_t w;
        w.r.funct7 = f7;
        w.r.rs2    = 5'd2;
        w.r.rs1    = 5'd1;
        w.r.funct3 = f3;
        w.r.rd     = 5'd3;
        w.r.opcode = opc;
        return w;
    endfunction

    function automatic rv_instr_t i_word(input logic [11:0] imm, input logic [2:0] f3);
        rv_instr_t w;
        w.i.imm12  = imm;
        w.i.rs1    = 5'd1;
        w.i.funct3 = f3;
        w.i.rd     = 5'd3;
        w.i.opcode = OPC_OP_IMM;
        return w;
    endfunction

    // expected result straight from the rv32i rules
    function automatic void ref_model(input rv_instr_t w, input logic [31:0] a,
                                      input logic [31:0] b, output logic [31:0] res,
                                      output logic ill);
        logic signed [31:0] sa;
        logic [31:0]        opb;
        logic [6:0]         f7;
        logic [2:0]         f3;
        logic               alt;
        sa  = a;
        f3  = w.r.funct3;
        res = '0;
        ill = 1'b0;
        f7  = 7'h00;
        opb = b;
        if (w.r.opcode == OPC_OP) begin
            f7 = w.r.funct7;
        end else if (w.r.opcode == OPC_OP_IMM) begin
            if (f3 == 3'd1 || f3 == 3'd5) f7 = w.i.imm12[11:5];  // only shifts carry funct7
            opb = {{20{w.i.imm12[11]}}, w.i.imm12};
        end else begin
            ill = 1'b1;
        end
        alt = (f7 == 7'h20);
        if (f7 != 7'h00 && !(alt && (f3 == 3'd0 || f3 == 3'd5))) ill = 1'b1;
        if (!ill) begin
            case (f3)
                3'd0: res = alt ? a - opb : a + opb;
                3'd1: res = a << opb[4:0];
                3'd2: res = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                3'd3: res = (a < opb) ? 32'd1 : 32'd0;
                3'd4: res = a ^ opb;
                3'd5: begin
                    if (alt) res = sa >>> opb[4:0];
                    else     res = a >> opb[4:0];
                end
                3'd6: res = a | opb;
                default: res = a & opb;
            endcase
        end
    endfunction

    task automatic push_row(input rv_instr_t w, input logic [31:0] a, input logic [31:0] b,
                            input int gap, input logic [31:0] exp_data, input logic exp_ill);
        row_t row;
        row.word     = w;
        row.a        = a;
        row.b        = b;
        row.idx      = ROB_IDX_W'(rows.size());
        row.gap      = gap;
        row.exp_data = exp_data;
        row.exp_ill  = exp_ill;
        rows.push_back(row);
    endtask

    task automatic add_row(input rv_instr_t w, input logic [31:0] a, input logic [31:0] b,
                           input int gap, input logic [31:0] exp_data, input logic exp_ill);
        logic [31:0] m_data;
        logic        m_ill;
        ref_model(w, a, b, m_data, m_ill);  // table value must agree with the model
        compare($sformatf("model data, row %0d", rows.size()), m_data, exp_data);
        compare($sformatf("model flag, row %0d", rows.size()), 32'(m_ill), 32'(exp_ill));
        push_row(w, a, b, gap, exp_data, exp_ill);
    endtask

    task automatic add_random_row();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] coin;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [31:0] d;
        logic        ill;
        rv_instr_t   w;
        a    = $random(seed);
        b    = $random(seed);
        coin = $random(seed);
        imm  = 12'($random(seed));
        f3   = 3'($random(seed));
        if (coin[0]) begin
            w = r_word((coin[1] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, f3, OPC_OP);
        end else begin
            if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = (coin[1] && f3 == 3'd5) ? 7'h20 : 7'h00;
            w = i_word(imm, f3);
        end
        ref_model(w, a, b, d, ill);
        push_row(w, a, b, 0, d, ill);
    endtask

    task automatic build_table();
        add_row(r_word(7'h00, 3'd0, OPC_OP), 32'd5, 32'd7, 10, 32'd12, 1'b0);
        add_row(r_word(7'h20, 3'd0, OPC_OP), 32'd3, 32'd5, 10, 32'hffff_fffe, 1'b0);
        add_row(r_word(7'h00, 3'd7, OPC_OP), 32'hf0f0_1234, 32'h0ff0_ff00, 0, 32'h00f0_1200, 1'b0);
        add_row(r_word(7'h00, 3'd6, OPC_OP), 32'hf000_000f, 32'h0000_f0f0, 0, 32'hf000_f0ff, 1'b0);
        add_row(r_word(7'h00, 3'd4, OPC_OP), 32'haaaa_5555, 32'hffff_0000, 0, 32'h5555_5555, 1'b0);
        add_row(r_word(7'h00, 3'd2, OPC_OP), 32'hffff_ffff, 32'd1, 0, 32'd1, 1'b0);
        add_row(r_word(7'h00, 3'd3, OPC_OP), 32'hffff_ffff, 32'd1, 0, 32'd0, 1'b0);
        add_row(r_word(7'h00, 3'd1, OPC_OP), 32'd1, 32'd36, 0, 32'h0000_0010, 1'b0);
        add_row(r_word(7'h00, 3'd5, OPC_OP), 32'h8000_0000, 32'd33, 0, 32'h4000_0000, 1'b0);
        add_row(r_word(7'h20, 3'd5, OPC_OP), 32'h8000_0000, 32'd33, 0, 32'hc000_0000, 1'b0);
        add_row(i_word(12'hfff, 3'd0), 32'd10, 32'hdead_beef, 10, 32'd9, 1'b0);
        add_row(i_word(12'h800, 3'd7), 32'h1234_5678, 32'd0, 0, 32'h1234_5000, 1'b0);
        add_row(i_word(12'h001, 3'd2), 32'hffff_fff0, 32'd0, 0, 32'd1, 1'b0);
        add_row(i_word(12'hfff, 3'd3), 32'd5, 32'd0, 0, 32'd1, 1'b0);
        add_row(i_word(12'hfff, 3'd4), 32'h0000_00ff, 32'd0, 0, 32'hffff_ff00, 1'b0);
        add_row(i_word(12'h0f0, 3'd6), 32'd1, 32'hffff_ffff, 0, 32'h0000_00f1, 1'b0);
        add_row(i_word(12'h01f, 3'd1), 32'd1, 32'hffff_ffff, 0, 32'h8000_0000, 1'b0);
        add_row(i_word(12'h004, 3'd5), 32'hf000_0000, 32'd7, 0, 32'h0f00_0000, 1'b0);
        add_row(i_word(12'h404, 3'd5), 32'hf000_0000, 32'd7, 0, 32'hff00_0000, 1'b0);
        add_row(r_word(7'h00, 3'd2, 7'b0000011), 32'd1, 32'd2, 10, 32'd0, 1'b1);  // load
        add_row(r_word(7'h01, 3'd0, OPC_OP), 32'd6, 32'd7, 0, 32'd0, 1'b1);  // mul
        add_row(r_word(7'h20, 3'd7, OPC_OP), 32'd6, 32'd7, 0, 32'd0, 1'b1);
        add_row(i_word(12'h401, 3'd1), 32'd6, 32'd7, 0, 32'd0, 1'b1);
        repeat (16) add_random_row();
    endtask

    task automatic dispatch_row(input int r);
        int   waited;
        exp_t e;
        waited = 0;
        if (rows[r].gap != 0) begin
            repeat (rows[r].gap) next_cycle();
            while (exp_q.size() != 0) begin
                if (waited == WAIT_LIMIT) begin
                    report_timeout($sformatf("draining before row %0d", r));
                    return;
                end
                next_cycle();
                waited++;
            end
        end
        instr_valid = 1'b1;
        instr       = rows[r].word;
        rs1_val     = rows[r].a;
        rs2_val     = rows[r].b;
        rob_idx     = rows[r].idx;
        waited      = 0;
        while (!instr_ready) begin
            saw_stall = 1'b1;
            if (waited == WAIT_LIMIT) begin
                report_timeout($sformatf("waiting for instr_ready on row %0d", r));
                instr_valid = 1'b0;
                return;
            end
            next_cycle();
            waited++;
        end
        next_cycle();  // transfer edge
        e.data  = rows[r].exp_data;
        e.idx   = rows[r].idx;
        e.ill   = rows[r].exp_ill;
        e.timed = (rows[r].gap != 0);
        e.xfer  = cycle;
        exp_q.push_back(e);
        instr_valid = 1'b0;
    endtask

    // results are sampled mid-cycle
    always @(negedge clk_in) begin
        exp_t e;
        if (!rst_in && result_valid) begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("result for rob index %0d at %0t ns with no instruction outstanding",
                         result_rob_idx, $time);
            end else begin
                e = exp_q.pop_front();
                compare("result_data", result_data, e.data);
                compare("result_rob_idx", 32'(result_rob_idx), 32'(e.idx));
                compare("result_illegal", 32'(result_illegal), 32'(e.ill));
                if (e.timed) compare("latency", 32'(cycle - e.xfer), 32'(ALU_LATENCY + 2));
            end
        end
    end

    initial begin
        int waited;
        rst_in      = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        rob_idx     = '0;
        build_table();
        repeat (5) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        repeat (3) begin
            compare("instr_ready after reset", 32'(instr_ready), 32'd1);
            compare("result_valid after reset", 32'(result_valid), 32'd0);
            next_cycle();
        end
        for (int r = 0; r < rows.size() && !timed_out; r++) dispatch_row(r);
        waited = 0;
        while (!timed_out && exp_q.size() != 0) begin
            if (waited == WAIT_LIMIT) report_timeout("waiting for the last results");
            next_cycle();
            waited++;
        end
        repeat (4) next_cycle();  // catch stray results
        if (!timed_out && !saw_stall) begin
            other_count++;
            $display("instr_ready never dropped during the back-to-back rows");
        end
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
alu_pkg.sv
alu_decode.sv
alu_issue_queue.sv
alu.sv
alu_cluster.sv
alu_cluster_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= alu_cluster_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
